// File: design/exec_pkg.sv
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int MUL_STAGES = 3;   // multiplier pipeline depth
    localparam int DIV_CYCLES = 33;  // one prep cycle plus one per quotient bit
    localparam int DIV_CNT_W  = $clog2(XLEN);

    typedef logic [DIV_CNT_W-1:0] div_cnt_t;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_NOR,
        OP_XOR,
        OP_LUI,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    typedef struct packed {
        alu_op_e         op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } exec_req_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            overflow;
    } exec_resp_t;

    // one producer's request to update HI and/or LO
    typedef struct packed {
        logic            hi_we;
        logic            lo_we;
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } hilo_wr_t;

endpackage

// File: design/alu_int.sv
`timescale 1ns/1ps

module alu_int (
    input  logic                         req_valid,
    input  exec_pkg::exec_req_t          req,
    input  logic [exec_pkg::XLEN-1:0]    hi,
    input  logic [exec_pkg::XLEN-1:0]    lo,
    output exec_pkg::exec_resp_t         resp,
    output logic                         resp_en,
    output exec_pkg::hilo_wr_t           move_wr
);

    logic                      sub_en;
    logic [exec_pkg::XLEN-1:0] b_in;
    logic [exec_pkg::XLEN-1:0] sum;
    logic                      cout;
    logic                      a_msb;
    logic                      slt_bit;
    logic                      sltu_bit;
    logic                      ovf_raw;
    logic [4:0]                shamt;

    // shared adder, subtract by inverting b and carrying in 1
    assign sub_en = req.op inside {exec_pkg::OP_SUB, exec_pkg::OP_SUBU,
                                   exec_pkg::OP_SLT, exec_pkg::OP_SLTU};
    assign b_in   = sub_en ? ~req.src2 : req.src2;
    assign {cout, sum} = {1'b0, req.src1} + {1'b0, b_in} + {{exec_pkg::XLEN{1'b0}}, sub_en};

    assign a_msb   = req.src1[exec_pkg::XLEN-1];
    assign ovf_raw = (a_msb == b_in[exec_pkg::XLEN-1]) && (sum[exec_pkg::XLEN-1] != a_msb);

    // signed less-than: signs differ, or same sign and the difference is negative
    assign slt_bit  = (a_msb & ~req.src2[exec_pkg::XLEN-1]) |
                      (~(a_msb ^ req.src2[exec_pkg::XLEN-1]) & sum[exec_pkg::XLEN-1]);
    assign sltu_bit = ~cout;  // borrow out

    assign shamt = req.src1[4:0];

    always_comb begin
        resp.overflow = 1'b0;
        case (req.op)
            exec_pkg::OP_ADD: begin
                resp.result   = sum;
                resp.overflow = ovf_raw;
            end
            exec_pkg::OP_SUB: begin
                resp.result   = sum;
                resp.overflow = ovf_raw;
            end
            exec_pkg::OP_ADDU,
            exec_pkg::OP_SUBU: resp.result = sum;
            exec_pkg::OP_SLT:  resp.result = {{(exec_pkg::XLEN-1){1'b0}}, slt_bit};
            exec_pkg::OP_SLTU: resp.result = {{(exec_pkg::XLEN-1){1'b0}}, sltu_bit};
            exec_pkg::OP_AND:  resp.result = req.src1 & req.src2;
            exec_pkg::OP_OR:   resp.result = req.src1 | req.src2;
            exec_pkg::OP_NOR:  resp.result = ~(req.src1 | req.src2);
            exec_pkg::OP_XOR:  resp.result = req.src1 ^ req.src2;
            exec_pkg::OP_LUI:  resp.result = {req.src2[15:0], 16'b0};
            exec_pkg::OP_SLL:  resp.result = req.src2 << shamt;
            exec_pkg::OP_SRL:  resp.result = req.src2 >> shamt;
            exec_pkg::OP_SRA:  resp.result = $signed(req.src2) >>> shamt;
            exec_pkg::OP_MFHI: resp.result = hi;
            exec_pkg::OP_MFLO: resp.result = lo;
            default:           resp.result = '0;
        endcase
    end

    // everything except the hi/lo producers returns a register result
    assign resp_en = req_valid &&
                     !(req.op inside {exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
                                      exec_pkg::OP_DIV, exec_pkg::OP_DIVU,
                                      exec_pkg::OP_MTHI, exec_pkg::OP_MTLO});

    assign move_wr.hi_we = req_valid && (req.op == exec_pkg::OP_MTHI);
    assign move_wr.lo_we = req_valid && (req.op == exec_pkg::OP_MTLO);
    assign move_wr.hi    = req.src1;  // rs goes to hi
    assign move_wr.lo    = req.src1;

endmodule

// File: design/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  exec_pkg::exec_req_t req,
    input  logic                cancel,
    output exec_pkg::hilo_wr_t  wr,
    output logic                busy
);

    logic                          go;
    logic                          sgn;
    logic [exec_pkg::MUL_STAGES-1:0] vld;  // one valid bit per stage

    logic [exec_pkg::XLEN-1:0]     a_mag;
    logic [exec_pkg::XLEN-1:0]     b_mag;
    logic                          neg1;
    logic [2*exec_pkg::XLEN-1:0]   prod;
    logic                          neg2;
    logic [2*exec_pkg::XLEN-1:0]   res;

    assign go  = start && (req.op inside {exec_pkg::OP_MULT, exec_pkg::OP_MULTU});
    assign sgn = (req.op == exec_pkg::OP_MULT);

    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld[0] <= go;  // a new issue survives a same-cycle cancel
            if (cancel)
                vld[exec_pkg::MUL_STAGES-1:1] <= '0;
            else
                vld[exec_pkg::MUL_STAGES-1:1] <= vld[exec_pkg::MUL_STAGES-2:0];
        end
    end

    always_ff @(posedge clk) begin
        // stage 1 magnitudes and result sign
        a_mag <= (sgn && req.src1[exec_pkg::XLEN-1]) ? -req.src1 : req.src1;
        b_mag <= (sgn && req.src2[exec_pkg::XLEN-1]) ? -req.src2 : req.src2;
        neg1  <= sgn && (req.src1[exec_pkg::XLEN-1] ^ req.src2[exec_pkg::XLEN-1]);
        // stage 2 unsigned product
        prod  <= {{exec_pkg::XLEN{1'b0}}, a_mag} * {{exec_pkg::XLEN{1'b0}}, b_mag};
        neg2  <= neg1;
        // stage 3 sign fixup
        res   <= neg2 ? -prod : prod;
    end

    assign wr.hi_we = vld[exec_pkg::MUL_STAGES-1];
    assign wr.lo_we = vld[exec_pkg::MUL_STAGES-1];
    assign wr.hi    = res[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
    assign wr.lo    = res[exec_pkg::XLEN-1:0];

    assign busy = |vld;

endmodule

// File: design/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  exec_pkg::exec_req_t req,
    input  logic                cancel,
    output exec_pkg::hilo_wr_t  wr,
    output logic                busy
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_PREP,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e                  state;
    exec_pkg::div_cnt_t          cnt;    // remaining run steps
    logic                        go;
    logic                        is_signed;
    logic                        neg_q;
    logic                        neg_r;
    logic [exec_pkg::XLEN-1:0]   quo;    // dividend shifts out, quotient shifts in
    logic [exec_pkg::XLEN-1:0]   dvs;
    logic [exec_pkg::XLEN-1:0]   rem;
    logic [exec_pkg::XLEN:0]     shifted;
    logic [exec_pkg::XLEN:0]     diff;
    logic                        take;

    assign go = start && (req.op inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU});

    // one restoring step
    assign shifted = {rem, quo[exec_pkg::XLEN-1]};
    assign diff    = shifted - {1'b0, dvs};
    assign take    = shifted >= {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else if (cancel && state != DIV_IDLE) begin
            state <= DIV_IDLE;  // abort
        end else begin
            case (state)
                DIV_IDLE: if (go) state <= DIV_PREP;
                DIV_PREP: begin
                    cnt   <= exec_pkg::div_cnt_t'(exec_pkg::DIV_CYCLES - 2);
                    state <= DIV_RUN;
                end
                DIV_RUN: begin
                    if (cnt == '0)
                        state <= DIV_DONE;
                    else
                        cnt <= cnt - 1'b1;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (go) begin
                    is_signed <= (req.op == exec_pkg::OP_DIV);
                    quo       <= req.src1;
                    dvs       <= req.src2;
                end
            end
            DIV_PREP: begin
                rem <= '0;
                if (dvs == '0) begin
                    // raw dividend and no sign fixup gives lo all ones, hi src1
                    neg_q <= 1'b0;
                    neg_r <= 1'b0;
                end else begin
                    neg_q <= is_signed && (quo[exec_pkg::XLEN-1] ^ dvs[exec_pkg::XLEN-1]);
                    neg_r <= is_signed && quo[exec_pkg::XLEN-1];
                    quo   <= (is_signed && quo[exec_pkg::XLEN-1]) ? -quo : quo;
                    dvs   <= (is_signed && dvs[exec_pkg::XLEN-1]) ? -dvs : dvs;
                end
            end
            DIV_RUN: begin
                rem <= take ? diff[exec_pkg::XLEN-1:0] : shifted[exec_pkg::XLEN-1:0];
                quo <= {quo[exec_pkg::XLEN-2:0], take};
            end
            default: ;
        endcase
    end

    assign wr.hi_we = (state == DIV_DONE);
    assign wr.lo_we = (state == DIV_DONE);
    assign wr.lo    = neg_q ? -quo : quo;  // quotient
    assign wr.hi    = neg_r ? -rem : rem;  // remainder follows dividend sign

    assign busy = (state != DIV_IDLE);

endmodule

// File: design/hilo_regs.sv
`timescale 1ns/1ps

module hilo_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  exec_pkg::hilo_wr_t        move_wr,
    input  exec_pkg::hilo_wr_t        mul_wr,
    input  exec_pkg::hilo_wr_t        div_wr,
    input  logic                      cancel,
    output logic [exec_pkg::XLEN-1:0] hi,
    output logic [exec_pkg::XLEN-1:0] lo
);

    exec_pkg::hilo_wr_t sel;

    // pick one producer per cycle
    always_comb begin
        if (div_wr.hi_we || div_wr.lo_we)
            sel = div_wr;
        else if (mul_wr.hi_we || mul_wr.lo_we)
            sel = mul_wr;
        else
            sel = move_wr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (!cancel) begin  // a killed instruction never lands
            if (sel.hi_we)
                hi <= sel.hi;
            if (sel.lo_we)
                lo <= sel.lo;
        end
    end

endmodule

// File: design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  exec_pkg::exec_req_t  req,
    input  logic                 cancel,
    output logic                 resp_valid,
    output exec_pkg::exec_resp_t resp,
    output logic                 busy
);

    exec_pkg::exec_resp_t      alu_resp;
    logic                      alu_resp_en;
    exec_pkg::hilo_wr_t        move_wr;
    exec_pkg::hilo_wr_t        mul_wr;
    exec_pkg::hilo_wr_t        div_wr;
    logic [exec_pkg::XLEN-1:0] hi;
    logic [exec_pkg::XLEN-1:0] lo;
    logic                      mul_busy;
    logic                      div_busy;

    alu_int i_alu (
        .req_valid (req_valid),
        .req       (req),
        .hi        (hi),
        .lo        (lo),
        .resp      (alu_resp),
        .resp_en   (alu_resp_en),
        .move_wr   (move_wr)
    );

    mul_unit i_mul (
        .clk    (clk),
        .reset  (reset),
        .start  (req_valid),
        .req    (req),
        .cancel (cancel),
        .wr     (mul_wr),
        .busy   (mul_busy)
    );

    div_unit i_div (
        .clk    (clk),
        .reset  (reset),
        .start  (req_valid),
        .req    (req),
        .cancel (cancel),
        .wr     (div_wr),
        .busy   (div_busy)
    );

    hilo_regs i_hilo (
        .clk     (clk),
        .reset   (reset),
        .move_wr (move_wr),
        .mul_wr  (mul_wr),
        .div_wr  (div_wr),
        .cancel  (cancel),
        .hi      (hi),
        .lo      (lo)
    );

    // register result lands one cycle after issue
    always_ff @(posedge clk) begin
        if (reset)
            resp_valid <= 1'b0;
        else
            resp_valid <= alu_resp_en;
    end

    always_ff @(posedge clk) begin
        resp <= alu_resp;
    end

    assign busy = mul_busy | div_busy;

endmodule

// File: dv/exec_chk.sv
`timescale 1ns/1ps

module exec_chk (
    input logic                clk,
    input logic                reset,
    input logic                req_valid,
    input exec_pkg::exec_req_t req,
    input logic                cancel,
    input logic                resp_valid,
    input logic                busy,
    input logic                div_busy,
    input exec_pkg::hilo_wr_t  div_wr
);

    logic reg_issue;  // alu ops, mfhi and mflo owe a register result

    assign reg_issue = req_valid &&
                       (req.op inside {[exec_pkg::OP_ADD:exec_pkg::OP_SRA],
                                       exec_pkg::OP_MFHI, exec_pkg::OP_MFLO});

    no_resp_out_of_reset: assert property (@(posedge clk) $fell(reset) |-> !resp_valid)
        else $error("resp_valid high in the first cycle after reset");

    busy_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(busy))
        else $error("busy is X or Z");

    // a response only ever answers a register-result issue
    resp_has_issue: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> $past(reg_issue))
        else $error("resp_valid without a register-result issue one cycle earlier");

    div_busy_held: assert property (@(posedge clk) disable iff (reset)
        div_busy && !div_wr.lo_we && !cancel |=> div_busy)
        else $error("divider dropped busy before writing HI/LO");

endmodule

// File: dv/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 req_valid;
    exec_pkg::exec_req_t  req;
    logic                 cancel;
    logic                 resp_valid;
    exec_pkg::exec_resp_t resp;
    logic                 busy;

    logic [31:0] hi_m;  // model HI
    logic [31:0] lo_m;  // model LO
    bit          passed;
    bit          fail_shown;

    exec_unit i_dut (.*);

    bind exec_unit exec_chk i_chk (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .cancel     (cancel),
        .resp_valid (resp_valid),
        .busy       (busy),
        .div_busy   (div_busy),
        .div_wr     (div_wr)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        fail_shown = 1'b1;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_resp(input exec_pkg::exec_resp_t got, input exec_pkg::exec_resp_t exp,
                              input exec_pkg::alu_op_e op);
        if (got.result !== exp.result)
            stop_with_failure($sformatf("ERROR resp.result (%s): got 0x%08h, expected 0x%08h",
                                        op.name(), got.result, exp.result));
        if (got.overflow !== exp.overflow)
            stop_with_failure($sformatf("ERROR resp.overflow (%s): got 0x%0h, expected 0x%0h",
                                        op.name(), got.overflow, exp.overflow));
    endtask

    task automatic check_hilo(input logic [31:0] got_hi, input logic [31:0] got_lo,
                              input logic [31:0] exp_hi, input logic [31:0] exp_lo);
        if (got_hi !== exp_hi)
            stop_with_failure($sformatf("ERROR hi: got 0x%08h, expected 0x%08h", got_hi, exp_hi));
        if (got_lo !== exp_lo)
            stop_with_failure($sformatf("ERROR lo: got 0x%08h, expected 0x%08h", got_lo, exp_lo));
    endtask

    // corner values show up often
    function automatic logic [31:0] pick_operand();
        case ($urandom_range(7, 0))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'($urandom_range(40, 0));
            default: return $urandom();
        endcase
    endfunction

    function automatic logic [31:0] pick_divisor();
        case ($urandom_range(5, 0))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            default: return pick_operand();
        endcase
    endfunction

    function automatic exec_pkg::exec_resp_t alu_expect(input exec_pkg::alu_op_e op,
                                                        input logic [31:0] a,
                                                        input logic [31:0] b);
        exec_pkg::exec_resp_t r;
        r.result   = '0;
        r.overflow = 1'b0;
        case (op)
            exec_pkg::OP_ADD, exec_pkg::OP_ADDU: begin
                r.result = a + b;
                if (op == exec_pkg::OP_ADD)  // same-sign operands, result sign flipped
                    r.overflow = (a[31] == b[31]) && (r.result[31] != a[31]);
            end
            exec_pkg::OP_SUB, exec_pkg::OP_SUBU: begin
                r.result = a - b;
                if (op == exec_pkg::OP_SUB)
                    r.overflow = (a[31] != b[31]) && (r.result[31] != a[31]);
            end
            exec_pkg::OP_SLT:  r.result = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::OP_SLTU: r.result = {31'b0, a < b};
            exec_pkg::OP_AND:  r.result = a & b;
            exec_pkg::OP_OR:   r.result = a | b;
            exec_pkg::OP_NOR:  r.result = ~(a | b);
            exec_pkg::OP_XOR:  r.result = a ^ b;
            exec_pkg::OP_LUI:  r.result = {b[15:0], 16'h0000};
            exec_pkg::OP_SLL:  r.result = b << a[4:0];  // amount from src1
            exec_pkg::OP_SRL:  r.result = b >> a[4:0];
            exec_pkg::OP_SRA:  r.result = $signed(b) >>> a[4:0];
            default: ;
        endcase
        return r;
    endfunction

    // {hi, lo} left by a multiply or divide
    function automatic logic [63:0] hilo_expect(input exec_pkg::alu_op_e op,
                                                input logic [31:0] a, input logic [31:0] b);
        logic   sgn;
        longint sa;
        longint sb;
        sgn = (op == exec_pkg::OP_MULT) || (op == exec_pkg::OP_DIV);
        sa  = sgn ? longint'($signed(a)) : longint'({32'b0, a});
        sb  = sgn ? longint'($signed(b)) : longint'({32'b0, b});
        if (op inside {exec_pkg::OP_MULT, exec_pkg::OP_MULTU})
            return sa * sb;
        if (b == 32'h0)
            return {a, 32'hffff_ffff};
        return {32'(sa % sb), 32'(sa / sb)};  // truncates toward zero
    endfunction

    task automatic strobe(input exec_pkg::alu_op_e op, input logic [31:0] a,
                          input logic [31:0] b);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{op: op, src1: a, src2: b};
    endtask

    task automatic release_req();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_resp(output exec_pkg::exec_resp_t got);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!resp_valid && n < 200);
        if (!resp_valid)
            stop_with_failure("resp_valid never came after a register-result issue");
        else if (n != 1)
            stop_with_failure($sformatf("resp_valid came %0d cycles after req_valid", n));
        got = resp;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (busy)
            stop_with_failure("busy never fell after a multiply or divide");
    endtask

    task automatic run_reg(input exec_pkg::alu_op_e op, input logic [31:0] a,
                           input logic [31:0] b, output exec_pkg::exec_resp_t got);
        strobe(op, a, b);
        release_req();
        wait_resp(got);
    endtask

    task automatic verify_hilo();
        exec_pkg::exec_resp_t got_hi;
        exec_pkg::exec_resp_t got_lo;
        run_reg(exec_pkg::OP_MFHI, $urandom(), $urandom(), got_hi);
        run_reg(exec_pkg::OP_MFLO, $urandom(), $urandom(), got_lo);
        check_hilo(got_hi.result, got_lo.result, hi_m, lo_m);
    endtask

    task automatic test_alu();
        exec_pkg::alu_op_e    op;
        logic [31:0]          a;
        logic [31:0]          b;
        exec_pkg::exec_resp_t got;
        op = exec_pkg::alu_op_e'(5'($urandom_range(13, 0)));  // OP_ADD up to OP_SRA
        a  = pick_operand();
        b  = pick_operand();
        run_reg(op, a, b, got);
        check_resp(got, alu_expect(op, a, b), op);
    endtask

    // multiply or divide, optionally killed by cancel while in flight
    task automatic test_long_op(input bit kill);
        exec_pkg::alu_op_e op;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [63:0]       exp;
        bit                is_div;
        int                n;
        int                delay;
        op     = exec_pkg::alu_op_e'(5'($urandom_range(17, 14)));
        is_div = op inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU};
        n      = (is_div || kill) ? 1 : $urandom_range(3, 1);
        repeat (n) begin  // multiplies go back to back
            a   = pick_operand();
            b   = pick_divisor();
            exp = hilo_expect(op, a, b);
            strobe(op, a, b);
        end
        release_req();
        if (kill) begin
            delay = is_div ? $urandom_range(exec_pkg::DIV_CYCLES + 1, 1)
                           : $urandom_range(exec_pkg::MUL_STAGES, 1);
            repeat (delay - 1) @(posedge clk);
            cancel <= 1'b1;
            @(posedge clk);
            cancel <= 1'b0;
            @(negedge clk);
            if (busy)
                stop_with_failure("busy still high one cycle after cancel");
        end else begin
            if (is_div)
                repeat ($urandom_range(3, 0)) test_alu();  // register ops while dividing
            wait_idle();
            {hi_m, lo_m} = exp;
        end
        verify_hilo();
    endtask

    task automatic test_move();
        exec_pkg::alu_op_e op;
        logic [31:0]       v;
        v  = pick_operand();
        op = exec_pkg::alu_op_e'(5'($urandom_range(21, 20)));  // mthi or mtlo
        strobe(op, v, pick_operand());
        release_req();
        if (op == exec_pkg::OP_MTHI)
            hi_m = v;
        else
            lo_m = v;
        verify_hilo();
    endtask

    initial begin
        int                kind;
        exec_pkg::alu_op_e op;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        cancel     = 1'b0;
        hi_m       = '0;
        lo_m       = '0;
        passed     = 1'b0;
        fail_shown = 1'b0;
        void'($urandom(51858));
        // requests under reset must leave no trace
        for (int i = 0; i < 15; i++) begin
            case (i % 5)
                0:       op = exec_pkg::OP_MTHI;
                1:       op = exec_pkg::OP_MTLO;
                2:       op = exec_pkg::OP_MULT;
                3:       op = exec_pkg::OP_DIV;
                default: op = exec_pkg::OP_NOR;  // owes a response
            endcase
            @(posedge clk);
            req_valid <= 1'b1;
            req       <= '{op: op, src1: $urandom() | 32'h1, src2: $urandom()};
        end
        @(posedge clk);
        reset     <= 1'b0;
        req_valid <= 1'b0;
        @(negedge clk);
        if (busy)
            stop_with_failure("busy high in the first cycle after reset");
        verify_hilo();  // zero out of reset
        for (int i = 0; i < 400; i++) begin
            kind = $urandom_range(9, 0);
            case (kind)
                0, 1, 2, 3: test_alu();
                4, 5:       test_long_op(1'b0);
                6:          test_move();
                7, 8:       test_long_op(1'b1);
                default:    verify_hilo();
            endcase
        end
        passed = 1'b1;
        $display("Simulation finished: PASS");
        $finish;
    end

    final begin
        if (!passed && !fail_shown)
            $display("Simulation finished: FAIL");
    end

endmodule

// File: vlog.f
design/exec_pkg.sv
design/alu_int.sv
design/mul_unit.sv
design/div_unit.sv
design/hilo_regs.sv
design/exec_unit.sv
dv/exec_chk.sv
dv/exec_tb.sv

// File: run.sh
#!/bin/sh
# build and run the exec_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module exec_tb -f vlog.f -o exec_sim
./obj_dir/exec_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run.sh: test passed"
    exit 0
fi
echo "run.sh: test failed"
exit 1
